//--- mem_ctrl_pkg.sv
`default_nettype none

package mem_ctrl_pkg;

    localparam int ADDR_WIDTH  = 18;
    localparam int OP_WIDTH    = 3;
    localparam int COORD_WIDTH = 10;

    // opcodes understood by the controller, all others are ignored
    localparam logic [OP_WIDTH-1:0] OP_RD  = 3'd1; // single read
    localparam logic [OP_WIDTH-1:0] OP_WR  = 3'd2; // single write
    localparam logic [OP_WIDTH-1:0] OP_NHI = 3'd3; // nearest neighbour zoom-in
    localparam logic [OP_WIDTH-1:0] OP_NH  = 3'd5; // decimation zoom-out

    localparam logic [ADDR_WIDTH-1:0] IMG_WIDTH = 18'd320; // pixels per memory row

    // memory access pacing
    localparam int ACCESS_CYCLES = 4;
    localparam int WAIT_WIDTH    = $clog2(ACCESS_CYCLES);
    localparam logic [WAIT_WIDTH-1:0] WAIT_LAST = WAIT_WIDTH'(ACCESS_CYCLES - 1);

    localparam int ALG_STEPS  = 200; // read+write pairs per zoom run
    localparam int STEP_WIDTH = $clog2(ALG_STEPS);
    localparam logic [STEP_WIDTH-1:0] STEP_LAST = STEP_WIDTH'(ALG_STEPS - 1);

    // frame buffer regions
    localparam logic [ADDR_WIDTH-1:0] NHI_RD_BASE = 18'd19200;
    localparam logic [ADDR_WIDTH-1:0] NHI_WR_BASE = 18'd76800;
    localparam logic [ADDR_WIDTH-1:0] NH_RD_BASE  = 18'd0;
    localparam logic [ADDR_WIDTH-1:0] NH_WR_BASE  = 18'd96000;

    // zoom-out writes into a centred 160 pixel window
    localparam logic [COORD_WIDTH-1:0] NH_X_FIRST  = 10'd80;
    localparam logic [COORD_WIDTH-1:0] NH_X_LAST   = 10'd239;
    localparam logic [COORD_WIDTH-1:0] NH_Y_FIRST  = 10'd60;
    localparam logic [COORD_WIDTH-1:0] NH_SRC_STEP = 10'd2; // source stride in x and y

    localparam logic [COORD_WIDTH-1:0] NHI_X_LAST = 10'd319; // last zoom-in column

    // sequencer state encoding
    localparam int STATE_WIDTH = 2;
    localparam logic [STATE_WIDTH-1:0] ST_IDLE  = 2'd0;
    localparam logic [STATE_WIDTH-1:0] ST_SETUP = 2'd1;
    localparam logic [STATE_WIDTH-1:0] ST_ISSUE = 2'd2;
    localparam logic [STATE_WIDTH-1:0] ST_WAIT  = 2'd3;

endpackage

`default_nettype wire

//--- access_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module access_sequencer (
    input  wire                                 clock,
    input  wire                                 rst_n,
    input  wire                                 enable,
    input  wire  [mem_ctrl_pkg::OP_WIDTH-1:0]   operation,
    output logic [mem_ctrl_pkg::OP_WIDTH-1:0]   mode,
    output logic                                start,
    output logic                                issue,
    output logic                                access_write,
    output logic                                advance,
    output logic                                done
);

    logic [mem_ctrl_pkg::STATE_WIDTH-1:0] state;
    logic [mem_ctrl_pkg::OP_WIDTH-1:0]    mode_q;
    logic [mem_ctrl_pkg::WAIT_WIDTH-1:0]  wait_cnt;
    logic [mem_ctrl_pkg::STEP_WIDTH-1:0]  step_cnt;
    logic                                 phase_wr; // 0 read, 1 write within a pair
    logic                                 is_single;
    logic                                 is_zoom;
    logic                                 accept;
    logic                                 last_cycle;
    logic                                 single_run;

    // opcode support is decided here only
    assign is_single = (operation == mem_ctrl_pkg::OP_RD) || (operation == mem_ctrl_pkg::OP_WR);
    assign is_zoom   = (operation == mem_ctrl_pkg::OP_NHI) || (operation == mem_ctrl_pkg::OP_NH);
    assign accept    = (state == mem_ctrl_pkg::ST_IDLE) && enable && (is_single || is_zoom);

    assign last_cycle = (state == mem_ctrl_pkg::ST_WAIT) && (wait_cnt == mem_ctrl_pkg::WAIT_LAST);
    assign single_run = (mode_q == mem_ctrl_pkg::OP_RD) || (mode_q == mem_ctrl_pkg::OP_WR);

    // while idle the incoming opcode is shown so that the acceptance edge can use it
    assign mode  = (state == mem_ctrl_pkg::ST_IDLE) ? operation : mode_q;
    assign start = accept && is_zoom;
    assign issue = (accept && is_single)
                || (state == mem_ctrl_pkg::ST_SETUP)
                || (state == mem_ctrl_pkg::ST_ISSUE);

    assign access_write = (state == mem_ctrl_pkg::ST_IDLE) ? (operation == mem_ctrl_pkg::OP_WR)
                                                           : phase_wr;
    assign advance = last_cycle && phase_wr; // write of a zoom pair finishing
    assign done    = (state == mem_ctrl_pkg::ST_IDLE);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state    <= mem_ctrl_pkg::ST_IDLE;
            mode_q   <= '0;
            wait_cnt <= '0;
            step_cnt <= '0;
            phase_wr <= 1'b0;
        end else begin
            case (state)
                mem_ctrl_pkg::ST_IDLE: begin
                    if (accept) begin
                        mode_q   <= operation;
                        wait_cnt <= '0;
                        step_cnt <= '0;
                        phase_wr <= 1'b0;
                        // single ops issue on this edge, zoom ops load the cursor first
                        state    <= is_zoom ? mem_ctrl_pkg::ST_SETUP : mem_ctrl_pkg::ST_WAIT;
                    end
                end
                mem_ctrl_pkg::ST_SETUP,
                mem_ctrl_pkg::ST_ISSUE: begin
                    wait_cnt <= '0;
                    state    <= mem_ctrl_pkg::ST_WAIT;
                end
                mem_ctrl_pkg::ST_WAIT: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (last_cycle) begin
                        if (single_run) begin
                            state <= mem_ctrl_pkg::ST_IDLE;
                        end else if (!phase_wr) begin
                            phase_wr <= 1'b1; // read done, write comes next
                            state    <= mem_ctrl_pkg::ST_ISSUE;
                        end else if (step_cnt == mem_ctrl_pkg::STEP_LAST) begin
                            state <= mem_ctrl_pkg::ST_IDLE; // last pair written
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                            phase_wr <= 1'b0;
                            state    <= mem_ctrl_pkg::ST_ISSUE;
                        end
                    end
                end
                default: begin
                    state <= mem_ctrl_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pixel_cursor.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_cursor (
    input  wire                                   clock,
    input  wire                                   rst_n,
    input  wire                                   start,
    input  wire                                   advance,
    input  wire  [mem_ctrl_pkg::OP_WIDTH-1:0]     mode,
    output logic [mem_ctrl_pkg::COORD_WIDTH-1:0]  dst_x,
    output logic [mem_ctrl_pkg::COORD_WIDTH-1:0]  dst_y,
    output logic [mem_ctrl_pkg::COORD_WIDTH-1:0]  src_x,
    output logic [mem_ctrl_pkg::COORD_WIDTH-1:0]  src_y
);

    logic is_nh;
    logic row_end;

    assign is_nh = (mode == mem_ctrl_pkg::OP_NH);

    // last destination column depends on the walk
    assign row_end = is_nh ? (dst_x == mem_ctrl_pkg::NH_X_LAST)
                           : (dst_x == mem_ctrl_pkg::NHI_X_LAST);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dst_x <= '0;
            dst_y <= '0;
            src_x <= '0;
            src_y <= '0;
        end else if (start) begin
            src_x <= '0;
            src_y <= '0;
            if (is_nh) begin
                dst_x <= mem_ctrl_pkg::NH_X_FIRST; // top-left of the centred window
                dst_y <= mem_ctrl_pkg::NH_Y_FIRST;
            end else begin
                dst_x <= '0;
                dst_y <= '0;
            end
        end else if (advance) begin
            if (row_end) begin
                dst_y <= dst_y + 1'b1;
                if (is_nh) begin
                    dst_x <= mem_ctrl_pkg::NH_X_FIRST;
                    src_x <= '0;
                    src_y <= src_y + mem_ctrl_pkg::NH_SRC_STEP; // skip every other source line
                end else begin
                    dst_x <= '0;
                end
            end else begin
                dst_x <= dst_x + 1'b1;
                if (is_nh) begin
                    src_x <= src_x + mem_ctrl_pkg::NH_SRC_STEP;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- address_former.sv
`timescale 1ns/1ps
`default_nettype none

module address_former (
    input  wire                                   clock,
    input  wire                                   rst_n,
    input  wire                                   issue,
    input  wire                                   access_write,
    input  wire  [mem_ctrl_pkg::OP_WIDTH-1:0]     mode,
    input  wire  [mem_ctrl_pkg::ADDR_WIDTH-1:0]   addr_base,
    input  wire  [mem_ctrl_pkg::COORD_WIDTH-1:0]  dst_x,
    input  wire  [mem_ctrl_pkg::COORD_WIDTH-1:0]  dst_y,
    input  wire  [mem_ctrl_pkg::COORD_WIDTH-1:0]  src_x,
    input  wire  [mem_ctrl_pkg::COORD_WIDTH-1:0]  src_y,
    output logic [mem_ctrl_pkg::ADDR_WIDTH-1:0]   addr_out,
    output logic                                  wr_enable
);

    logic [mem_ctrl_pkg::ADDR_WIDTH-1:0] dst_offset;
    logic [mem_ctrl_pkg::ADDR_WIDTH-1:0] src_offset;
    logic [mem_ctrl_pkg::ADDR_WIDTH-1:0] half_offset;
    logic [mem_ctrl_pkg::ADDR_WIDTH-1:0] next_addr;
    logic [mem_ctrl_pkg::WAIT_WIDTH-1:0] wr_cnt;

    function automatic logic [mem_ctrl_pkg::ADDR_WIDTH-1:0] pixel_offset(
        input logic [mem_ctrl_pkg::COORD_WIDTH-1:0] col,
        input logic [mem_ctrl_pkg::COORD_WIDTH-1:0] row
    );
        return col + row * mem_ctrl_pkg::IMG_WIDTH;
    endfunction

    assign dst_offset  = pixel_offset(dst_x, dst_y);
    assign src_offset  = pixel_offset(src_x, src_y);
    assign half_offset = (dst_x >> 1) + ((dst_y * mem_ctrl_pkg::IMG_WIDTH) >> 1); // zoom-in source

    always_comb begin
        case (mode)
            mem_ctrl_pkg::OP_NHI: next_addr = access_write
                                            ? mem_ctrl_pkg::NHI_WR_BASE + dst_offset
                                            : mem_ctrl_pkg::NHI_RD_BASE + half_offset;
            mem_ctrl_pkg::OP_NH:  next_addr = access_write
                                            ? mem_ctrl_pkg::NH_WR_BASE + dst_offset
                                            : mem_ctrl_pkg::NH_RD_BASE + src_offset;
            default:              next_addr = addr_base; // single read or write
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            addr_out  <= '0;
            wr_enable <= 1'b0;
            wr_cnt    <= '0;
        end else if (issue) begin
            addr_out  <= next_addr;
            wr_enable <= access_write;
            wr_cnt    <= '0;
        end else if (wr_enable) begin
            wr_cnt <= wr_cnt + 1'b1;
            if (wr_cnt == mem_ctrl_pkg::WAIT_LAST) begin
                wr_enable <= 1'b0; // write window over
            end
        end
    end

endmodule

`default_nettype wire

//--- memory_control.sv
`timescale 1ns/1ps
`default_nettype none

module memory_control (
    input  wire                                 clock,
    input  wire                                 rst_n,
    input  wire                                 enable,
    input  wire  [mem_ctrl_pkg::OP_WIDTH-1:0]   operation,
    input  wire  [mem_ctrl_pkg::ADDR_WIDTH-1:0] addr_base,
    output logic [mem_ctrl_pkg::ADDR_WIDTH-1:0] addr_out,
    output logic                                wr_enable,
    output logic                                done
);

    logic [mem_ctrl_pkg::OP_WIDTH-1:0]    mode;
    logic                                 start;
    logic                                 issue;
    logic                                 access_write;
    logic                                 advance;
    logic [mem_ctrl_pkg::COORD_WIDTH-1:0] dst_x;
    logic [mem_ctrl_pkg::COORD_WIDTH-1:0] dst_y;
    logic [mem_ctrl_pkg::COORD_WIDTH-1:0] src_x;
    logic [mem_ctrl_pkg::COORD_WIDTH-1:0] src_y;

    access_sequencer i_access_sequencer (
        .clock        (clock),
        .rst_n        (rst_n),
        .enable       (enable),
        .operation    (operation),
        .mode         (mode),
        .start        (start),
        .issue        (issue),
        .access_write (access_write),
        .advance      (advance),
        .done         (done)
    );

    pixel_cursor i_pixel_cursor (
        .clock   (clock),
        .rst_n   (rst_n),
        .start   (start),
        .advance (advance),
        .mode    (mode),
        .dst_x   (dst_x),
        .dst_y   (dst_y),
        .src_x   (src_x),
        .src_y   (src_y)
    );

    address_former i_address_former (
        .clock        (clock),
        .rst_n        (rst_n),
        .issue        (issue),
        .access_write (access_write),
        .mode         (mode),
        .addr_base    (addr_base),
        .dst_x        (dst_x),
        .dst_y        (dst_y),
        .src_x        (src_x),
        .src_y        (src_y),
        .addr_out     (addr_out),
        .wr_enable    (wr_enable)
    );

endmodule

`default_nettype wire

//--- memory_control_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module memory_control_asserts (
    input wire                                 clock,
    input wire                                 rst_n,
    input wire                                 enable,
    input wire [mem_ctrl_pkg::ADDR_WIDTH-1:0]  addr_out,
    input wire                                 wr_enable,
    input wire                                 done
);

    // a write only happens while an operation is running
    write_while_busy: assert property (@(posedge clock) disable iff (!rst_n)
        wr_enable |-> !done)
        else $error("wr_enable high while done is high");

    // one write window is exactly four cycles
    write_window: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(wr_enable) |-> wr_enable [*4] ##1 !wr_enable)
        else $error("wr_enable window is not four cycles long");

    idle_address_hold: assert property (@(posedge clock) disable iff (!rst_n)
        (done && !enable) |-> $stable(addr_out))
        else $error("addr_out changed while idle");

endmodule

`default_nettype wire

//--- tb_memory_control.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory_control;

    localparam int ROWS         = 10;
    localparam int ZOOM_COUNT   = 2 * mem_ctrl_pkg::ALG_STEPS;
    localparam int DONE_TIMEOUT = 20; // cycles allowed for done to come back

    logic                                clock;
    logic                                rst_n;
    logic                                enable;
    logic [mem_ctrl_pkg::OP_WIDTH-1:0]   operation;
    logic [mem_ctrl_pkg::ADDR_WIDTH-1:0] addr_base;
    wire  [mem_ctrl_pkg::ADDR_WIDTH-1:0] addr_out;
    wire                                 wr_enable;
    wire                                 done;

    logic [31:0] rng_state;
    int          mismatches;
    int          timeouts;

    // stimulus table, one row per operation: opcode, base, accesses, accepted
    logic [mem_ctrl_pkg::OP_WIDTH-1:0]   tbl_op     [ROWS] = '{1, 2, 3, 5, 0, 4, 6, 7, 2, 1};
    logic [mem_ctrl_pkg::ADDR_WIDTH-1:0] tbl_base   [ROWS];
    int tbl_count [ROWS] = '{1, 1, ZOOM_COUNT, ZOOM_COUNT, 0, 0, 0, 0, 1, 1};
    bit tbl_accept[ROWS] = '{1, 1, 1, 1, 0, 0, 0, 0, 1, 1};

    memory_control i_memory_control (
        .clock     (clock),
        .rst_n     (rst_n),
        .enable    (enable),
        .operation (operation),
        .addr_base (addr_base),
        .addr_out  (addr_out),
        .wr_enable (wr_enable),
        .done      (done)
    );

    bind memory_control memory_control_asserts i_memory_control_asserts (
        .clock     (clock),
        .rst_n     (rst_n),
        .enable    (enable),
        .addr_out  (addr_out),
        .wr_enable (wr_enable),
        .done      (done)
    );

    always #20 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // n-th access of a zoom run, even n reads and odd n writes
    function automatic logic [31:0] zoom_address(input logic [2:0] op, input int n);
        int pair;
        int col;
        int row;
        pair = n / 2;
        if (op == mem_ctrl_pkg::OP_NHI) begin
            col = pair % 320;
            row = pair / 320;
            return (n % 2) ? 76800 + col + row * 320 : 19200 + col / 2 + (row * 320) / 2;
        end
        col = pair % 160; // centred window is 160 pixels wide
        row = pair / 160;
        return (n % 2) ? 96000 + (80 + col) + (60 + row) * 320 : 2 * col + 2 * row * 320;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
        mismatches++;
    endtask

    task automatic wait_done(input int r);
        int n;
        n = 0;
        while (done !== 1'b1 && n < DONE_TIMEOUT) begin
            @(negedge clock);
            n++;
        end
        if (done !== 1'b1) begin
            $display("timeout: done never returned high after table row %0d", r);
            timeouts++;
        end
    endtask

    task automatic run_row(input int r);
        int                                  pos;
        int                                  k;
        int                                  c;
        int                                  offset;
        logic                                is_write;
        logic [mem_ctrl_pkg::ADDR_WIDTH-1:0] exp_addr;
        logic [mem_ctrl_pkg::ADDR_WIDTH-1:0] prev_addr;
        @(negedge clock);
        prev_addr = addr_out;
        @(posedge clock);
        operation <= tbl_op[r];
        addr_base <= tbl_base[r];
        enable    <= 1'b1;
        @(posedge clock); // acceptance edge when the opcode is supported
        if (!tbl_accept[r]) begin
            for (c = 0; c < 10; c++) begin
                @(negedge clock);
                if (done !== 1'b1) report_mismatch("done", 1, done);
                if (wr_enable !== 1'b0) report_mismatch("wr_enable", 0, wr_enable);
                if (addr_out !== prev_addr) report_mismatch("addr_out", prev_addr, addr_out);
            end
            @(posedge clock);
            enable <= 1'b0;
        end else begin
            enable <= 1'b0;
            pos    = 0;
            offset = (tbl_count[r] == 1) ? 0 : 1; // zoom runs spend one setup edge
            for (k = 0; k < tbl_count[r]; k++) begin
                while (pos < offset + 5 * k) begin
                    @(posedge clock);
                    pos++;
                end
                is_write = (tbl_count[r] == 1) ? (tbl_op[r] == mem_ctrl_pkg::OP_WR) : (k % 2);
                exp_addr = (tbl_count[r] == 1) ? tbl_base[r] : zoom_address(tbl_op[r], k);
                for (c = 0; c < mem_ctrl_pkg::ACCESS_CYCLES; c++) begin
                    @(negedge clock);
                    if (c == 0 && addr_out !== exp_addr) begin
                        report_mismatch("addr_out", exp_addr, addr_out);
                    end
                    if (wr_enable !== is_write) report_mismatch("wr_enable", is_write, wr_enable);
                    if (done !== 1'b0) report_mismatch("done", 0, done);
                    @(posedge clock);
                    pos++;
                end
                @(negedge clock);
                if (wr_enable !== 1'b0) report_mismatch("wr_enable", 0, wr_enable);
            end
            wait_done(r);
        end
    endtask

    initial begin
        int r;
        clock      = 1'b0;
        rst_n      = 1'b0;
        enable     = 1'b0;
        operation  = '0;
        addr_base  = '0;
        mismatches = 0;
        timeouts   = 0;
        rng_state  = 32'h9f403829;
        for (r = 0; r < ROWS; r++) begin
            rng_state   = xorshift(rng_state);
            tbl_base[r] = rng_state[mem_ctrl_pkg::ADDR_WIDTH-1:0];
        end
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        if (done !== 1'b1) report_mismatch("done", 1, done);
        if (wr_enable !== 1'b0) report_mismatch("wr_enable", 0, wr_enable);
        if (addr_out !== '0) report_mismatch("addr_out", 0, addr_out);
        for (r = 0; r < ROWS; r++) begin
            run_row(r);
        end
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
mem_ctrl_pkg.sv
access_sequencer.sv
pixel_cursor.sv
address_former.sv
memory_control.sv
memory_control_asserts.sv
tb_memory_control.sv

//--- Bender.yml
package:
  name: memory_control

sources:
  - mem_ctrl_pkg.sv
  - access_sequencer.sv
  - pixel_cursor.sv
  - address_former.sv
  - memory_control.sv
  - target: test
    files:
      - memory_control_asserts.sv
      - tb_memory_control.sv
